// ==== source/debug_pkg.sv ====
package debug_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    localparam int NUM_REGISTERS = 32;

    // Register 0 sits in the lowest word
    typedef logic [NUM_REGISTERS*32-1:0] regfile_t;
    typedef logic [31:0]                 if_id_t;
    typedef logic [5:0]                  mem_addr_t;  // 64-byte data memory

    typedef enum logic [7:0] {
        CMD_DUMP_REGS  = 8'h01,
        CMD_DUMP_IF_ID = 8'h02,
        CMD_CONTINUOUS = 8'h08,
        CMD_STEP_MODE  = 8'h09,
        CMD_STEP       = 8'h0A,
        CMD_READ_MEM   = 8'h0B
    } cmd_e;

    localparam byte_t ACK_BYTE = 8'h52;  // 'R'

    localparam int OVERSAMPLE = 16;  // Ticks per serial bit

endpackage

// ==== source/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx import debug_pkg::*; #(
    parameter int CLKS_PER_TICK = 131
) (
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_rx,
    output byte_t o_data,
    output logic  o_valid
);

    localparam int CW  = $clog2(CLKS_PER_TICK + 1);
    localparam int OSW = $clog2(OVERSAMPLE);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e      state;
    logic [1:0]     rx_sync;
    logic           rx;
    logic [CW-1:0]  clk_cnt;
    logic           tick;
    logic [OSW-1:0] os_cnt;
    logic [2:0]     bit_idx;
    byte_t          shift;

    assign rx     = rx_sync[1];
    assign tick   = (state != RX_IDLE) && (clk_cnt == CW'(CLKS_PER_TICK - 1));
    assign o_data = shift;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            rx_sync <= 2'b11;  // Line idles high
            state   <= RX_IDLE;
            clk_cnt <= '0;
            os_cnt  <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
            o_valid <= 1'b0;
            clk_cnt <= (tick || state == RX_IDLE) ? '0 : clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    os_cnt <= '0;
                    if (!rx) begin
                        state <= RX_START;
                    end
                end
                RX_START: if (tick) begin
                    if (os_cnt == OSW'(OVERSAMPLE/2 - 1)) begin
                        os_cnt  <= '0;
                        bit_idx <= '0;
                        state   <= rx ? RX_IDLE : RX_DATA;  // Glitch, not a start bit
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                RX_DATA: if (tick) begin
                    if (os_cnt == OSW'(OVERSAMPLE - 1)) begin
                        os_cnt  <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                default: if (tick) begin
                    if (os_cnt == OSW'(OVERSAMPLE - 1)) begin
                        o_valid <= 1'b1;  // Middle of stop bit
                        state   <= RX_IDLE;
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && tick && os_cnt == OSW'(OVERSAMPLE - 1)) begin
            shift <= {rx, shift[7:1]};  // LSB arrives first
        end
    end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx import debug_pkg::*; #(
    parameter int CLKS_PER_TICK = 131
) (
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_start,
    input  byte_t i_data,
    output logic  o_tx,
    output logic  o_busy,
    output logic  o_done
);

    localparam int CW  = $clog2(CLKS_PER_TICK + 1);
    localparam int OSW = $clog2(OVERSAMPLE);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e      state;
    logic [CW-1:0]  clk_cnt;
    logic           tick;
    logic           bit_end;
    logic [OSW-1:0] os_cnt;
    logic [2:0]     bit_idx;
    byte_t          shift;

    assign o_busy  = (state != TX_IDLE);
    assign tick    = o_busy && (clk_cnt == CW'(CLKS_PER_TICK - 1));
    assign bit_end = tick && (os_cnt == OSW'(OVERSAMPLE - 1));
    assign o_tx    = (state == TX_START) ? 1'b0 :
                     (state == TX_DATA)  ? shift[0] : 1'b1;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            os_cnt  <= '0;
            bit_idx <= '0;
            o_done  <= 1'b0;
        end else begin
            o_done  <= 1'b0;
            clk_cnt <= (tick || !o_busy) ? '0 : clk_cnt + 1'b1;
            if (tick) begin
                os_cnt <= os_cnt + 1'b1;  // Wraps at OVERSAMPLE
            end
            case (state)
                TX_IDLE: begin
                    os_cnt  <= '0;
                    bit_idx <= '0;
                    if (i_start) begin
                        state <= TX_START;
                    end
                end
                TX_START: if (bit_end) state <= TX_DATA;
                TX_DATA: if (bit_end) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state <= TX_STOP;
                    end
                end
                default: if (bit_end) begin
                    o_done <= 1'b1;  // End of stop bit
                    state  <= TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_start) begin
            shift <= i_data;
        end else if (state == TX_DATA && bit_end) begin
            shift <= shift >> 1;
        end
    end

endmodule

// ==== source/command_decoder.sv ====
`timescale 1ns/10ps

module command_decoder import debug_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_rx_valid,
    input  byte_t      i_rx_data,
    output logic [2:0] o_dump_start,
    input  logic       i_dump_done,
    output mem_addr_t  o_mem_addr,
    output logic       o_step_enable,
    output logic       o_ack_req,
    output byte_t      o_ack_data,
    input  logic       i_ack_ack
);

    typedef enum logic [2:0] {
        DEC_IDLE, DEC_WAIT_ADDR, DEC_MEM_START, DEC_WAIT_DUMP, DEC_ACK_REQ, DEC_ACK_RELEASE
    } dec_state_e;

    dec_state_e state;
    logic       continuous;
    logic       step_pulse;

    assign o_ack_req     = (state == DEC_ACK_REQ);
    assign o_ack_data    = ACK_BYTE;
    assign o_step_enable = continuous | step_pulse;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state        <= DEC_IDLE;
            continuous   <= 1'b1;
            step_pulse   <= 1'b0;
            o_dump_start <= '0;
            o_mem_addr   <= '0;
        end else begin
            step_pulse   <= 1'b0;
            o_dump_start <= '0;
            case (state)
                DEC_IDLE: if (i_rx_valid) begin
                    case (i_rx_data)
                        CMD_DUMP_REGS: begin
                            o_dump_start <= 3'b001;
                            state        <= DEC_WAIT_DUMP;
                        end
                        CMD_DUMP_IF_ID: begin
                            o_dump_start <= 3'b010;
                            state        <= DEC_WAIT_DUMP;
                        end
                        CMD_READ_MEM: state <= DEC_WAIT_ADDR;
                        CMD_CONTINUOUS: begin
                            continuous <= 1'b1;
                            state      <= DEC_ACK_REQ;
                        end
                        CMD_STEP_MODE: begin
                            continuous <= 1'b0;
                            state      <= DEC_ACK_REQ;
                        end
                        CMD_STEP: step_pulse <= !continuous;  // Silent, no reply
                        default: ;  // Unknown byte dropped
                    endcase
                end
                DEC_WAIT_ADDR: if (i_rx_valid) begin
                    o_mem_addr <= i_rx_data[5:0];
                    state      <= DEC_MEM_START;
                end
                DEC_MEM_START: begin
                    o_dump_start <= 3'b100;  // Memory word settled by now
                    state        <= DEC_WAIT_DUMP;
                end
                DEC_WAIT_DUMP: if (i_dump_done) state <= DEC_ACK_REQ;
                DEC_ACK_REQ: if (i_ack_ack) state <= DEC_ACK_RELEASE;
                default: if (!i_ack_ack) state <= DEC_IDLE;
            endcase
        end
    end

endmodule

// ==== source/snapshot_sender.sv ====
`timescale 1ns/10ps

module snapshot_sender import debug_pkg::*; #(
    parameter type payload_t = word_t
) (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_start,
    input  payload_t i_payload,
    output logic     o_req,
    output byte_t    o_data,
    input  logic     i_ack,
    output logic     o_done
);

    localparam int NUM_BYTES = ($bits(payload_t) + 7) / 8;
    localparam int BUF_W     = NUM_BYTES * 8;
    localparam int IDX_W     = (NUM_BYTES > 1) ? $clog2(NUM_BYTES) : 1;

    typedef enum logic [1:0] {SND_IDLE, SND_REQ, SND_RELEASE} snd_state_e;

    snd_state_e       state;
    logic [IDX_W-1:0] idx;
    logic [BUF_W-1:0] buffer;

    assign o_req  = (state == SND_REQ);
    assign o_data = buffer[idx*8 +: 8];

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state  <= SND_IDLE;
            idx    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                SND_IDLE: if (i_start) begin
                    idx   <= '0;
                    state <= SND_REQ;
                end
                SND_REQ: if (i_ack) state <= SND_RELEASE;
                default: if (!i_ack) begin
                    if (idx == IDX_W'(NUM_BYTES - 1)) begin
                        o_done <= 1'b1;
                        state  <= SND_IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= SND_REQ;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == SND_IDLE && i_start) begin
            buffer <= BUF_W'(i_payload);  // Zero padded to whole bytes
        end
    end

endmodule

// ==== source/tx_arbiter.sv ====
`timescale 1ns/10ps

module tx_arbiter import debug_pkg::*; #(
    parameter int NUM_REQ = 4
) (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic [NUM_REQ-1:0] i_req,
    input  byte_t              i_data [NUM_REQ],
    output logic [NUM_REQ-1:0] o_ack,
    output logic               o_tx_start,
    output byte_t              o_tx_data,
    input  logic               i_tx_done
);

    localparam int IDX_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

    typedef enum logic [1:0] {ARB_IDLE, ARB_SEND, ARB_ACK} arb_state_e;

    arb_state_e       state;
    logic [IDX_W-1:0] grant;
    logic [IDX_W-1:0] winner;

    // Lowest index wins
    always_comb begin
        winner = '0;
        for (int k = NUM_REQ - 1; k >= 0; k--) begin
            if (i_req[k]) begin
                winner = IDX_W'(k);
            end
        end
    end

    assign o_tx_data = i_data[grant];
    assign o_ack     = (state == ARB_ACK) ? NUM_REQ'(1) << grant : '0;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state      <= ARB_IDLE;
            grant      <= '0;
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            case (state)
                ARB_IDLE: if (|i_req) begin
                    grant      <= winner;
                    o_tx_start <= 1'b1;
                    state      <= ARB_SEND;
                end
                ARB_SEND: if (i_tx_done) state <= ARB_ACK;
                default: if (!i_req[grant]) state <= ARB_IDLE;  // Grant released
            endcase
        end
    end

endmodule

// ==== source/debug_unit.sv ====
`timescale 1ns/10ps

module debug_unit import debug_pkg::*; #(
    parameter int CLKS_PER_TICK = 131,
    parameter int NUM_REQ       = 4
) (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_uart_rx,
    input  regfile_t  i_registers,
    input  if_id_t    i_if_id,
    input  word_t     i_mem_data,
    output logic      o_uart_tx,
    output mem_addr_t o_mem_addr,
    output logic      o_step_enable
);

    byte_t              rx_data;
    logic               rx_valid;
    logic [2:0]         dump_start;
    logic [2:0]         sender_done;
    logic               dump_done;
    logic [NUM_REQ-1:0] arb_req;
    logic [NUM_REQ-1:0] arb_ack;
    byte_t              arb_data [NUM_REQ];
    logic               tx_start;
    byte_t              tx_data;
    logic               tx_done;

    assign dump_done = |sender_done;

    uart_rx #(.CLKS_PER_TICK(CLKS_PER_TICK)) u_uart_rx (
        .i_clk(i_clk), .i_reset(i_reset), .i_rx(i_uart_rx),
        .o_data(rx_data), .o_valid(rx_valid)
    );

    command_decoder u_decoder (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_rx_valid(rx_valid), .i_rx_data(rx_data),
        .o_dump_start(dump_start), .i_dump_done(dump_done),
        .o_mem_addr(o_mem_addr), .o_step_enable(o_step_enable),
        .o_ack_req(arb_req[0]), .o_ack_data(arb_data[0]), .i_ack_ack(arb_ack[0])
    );

    snapshot_sender #(.payload_t(regfile_t)) u_regs_sender (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(dump_start[0]), .i_payload(i_registers),
        .o_req(arb_req[1]), .o_data(arb_data[1]), .i_ack(arb_ack[1]), .o_done(sender_done[0])
    );

    snapshot_sender #(.payload_t(if_id_t)) u_if_id_sender (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(dump_start[1]), .i_payload(i_if_id),
        .o_req(arb_req[2]), .o_data(arb_data[2]), .i_ack(arb_ack[2]), .o_done(sender_done[1])
    );

    snapshot_sender #(.payload_t(word_t)) u_mem_sender (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(dump_start[2]), .i_payload(i_mem_data),
        .o_req(arb_req[3]), .o_data(arb_data[3]), .i_ack(arb_ack[3]), .o_done(sender_done[2])
    );

    tx_arbiter #(.NUM_REQ(NUM_REQ)) u_arbiter (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_req(arb_req), .i_data(arb_data), .o_ack(arb_ack),
        .o_tx_start(tx_start), .o_tx_data(tx_data), .i_tx_done(tx_done)
    );

    uart_tx #(.CLKS_PER_TICK(CLKS_PER_TICK)) u_uart_tx (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(tx_start), .i_data(tx_data),
        .o_tx(o_uart_tx), .o_busy(), .o_done(tx_done)
    );

endmodule

// ==== verification/debug_unit_assertions.sv ====
`timescale 1ns/10ps

module debug_unit_assertions import debug_pkg::*; #(
    parameter int NUM_REQ = 4
) (
    input logic               i_clk,
    input logic               i_reset,
    input logic [NUM_REQ-1:0] i_req,
    input byte_t              i_data [NUM_REQ],
    input logic [NUM_REQ-1:0] o_ack
);

    int failures = 0;

    a_one_ack: assert property (@(posedge i_clk) disable iff (i_reset) $onehot0(o_ack))
        else begin
            $error("more than one arbiter ack is high");
            failures++;
        end

    for (genvar k = 0; k < NUM_REQ; k++) begin : g_port
        a_ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
            $rose(o_ack[k]) |-> i_req[k])
            else begin
                $error("ack %0d rose without its req", k);
                failures++;
            end
        a_req_held: assert property (@(posedge i_clk) disable iff (i_reset)
            $fell(i_req[k]) |-> $past(o_ack[k]))
            else begin
                $error("req %0d fell before its ack", k);
                failures++;
            end
        a_data_stable: assert property (@(posedge i_clk) disable iff (i_reset)
            (i_req[k] && $past(i_req[k])) |-> (i_data[k] == $past(i_data[k])))
            else begin
                $error("data on port %0d changed while req was high", k);
                failures++;
            end
    end

endmodule

bind tx_arbiter debug_unit_assertions #(.NUM_REQ(NUM_REQ)) u_assertions (
    .i_clk(i_clk), .i_reset(i_reset), .i_req(i_req), .i_data(i_data), .o_ack(o_ack)
);

// ==== verification/debug_unit_checker.sv ====
`timescale 1ns/10ps

module debug_unit_checker import debug_pkg::*; #(
    parameter int BIT_CLKS = 32
) (
    input  logic      i_clk,
    input  logic      i_tx,
    input  logic      i_step_enable,
    input  mem_addr_t i_mem_addr,
    input  regfile_t  i_registers,
    input  if_id_t    i_if_id,
    input  logic      i_start,
    input  byte_t     i_cmd,
    input  byte_t     i_arg,
    input  byte_t     i_kind,
    output logic      o_idle,
    output int        o_passed,
    output int        o_failed
);

    localparam int BYTE_TIMEOUT = 4000;
    localparam int QUIET_CLKS   = 1200;  // Covers the command frame plus decode

    int test_num;
    int errors;

    task automatic wait_clks(input int n);
        repeat (n) @(negedge i_clk);
    endtask

    task automatic receive_byte(output byte_t b, output logic ok);
        int t;
        ok = 1'b0;
        b  = '0;
        t  = 0;
        while (i_tx && t < BYTE_TIMEOUT) begin
            @(negedge i_clk);
            t++;
        end
        if (i_tx) begin
            $display("timeout: no start bit from the DUT within %0d cycles", BYTE_TIMEOUT);
            return;
        end
        wait_clks(BIT_CLKS / 2);  // Middle of start bit
        if (i_tx) begin
            $display("start bit on o_uart_tx did not stay low");
            return;
        end
        for (int i = 0; i < 8; i++) begin
            wait_clks(BIT_CLKS);
            b[i] = i_tx;
        end
        wait_clks(BIT_CLKS);
        if (!i_tx) begin
            $display("stop bit missing on o_uart_tx");
            return;
        end
        ok = 1'b1;
    endtask

    task automatic check_byte(input byte_t exp, input string what, input int n);
        byte_t got;
        logic  ok;
        receive_byte(got, ok);
        if (!ok) begin
            errors++;
        end else if (got != exp) begin
            $display("[ERROR] %0t: %s byte %0d is %h, expected %h", $time, what, n, got, exp);
            errors++;
        end
    endtask

    // No reply allowed, counts step enable high cycles
    task automatic check_quiet(output int high_cycles);
        high_cycles = 0;
        for (int i = 0; i < QUIET_CLKS; i++) begin
            @(negedge i_clk);
            if (i_step_enable) begin
                high_cycles++;
            end
            if (!i_tx) begin
                $display("unexpected reply on o_uart_tx for command %h", i_cmd);
                errors++;
                break;
            end
        end
    endtask

    task automatic run_test();
        word_t exp_word;
        int    high_cycles;
        errors = 0;
        case (i_kind)
            8'h01: begin
                for (int i = 0; i < NUM_REGISTERS * 4; i++) begin
                    check_byte(i_registers[i*8 +: 8], "register dump", i);
                end
                check_byte(ACK_BYTE, "acknowledge", 0);
            end
            8'h02: begin
                for (int i = 0; i < 4; i++) begin
                    check_byte(i_if_id[i*8 +: 8], "IF/ID dump", i);
                end
                check_byte(ACK_BYTE, "acknowledge", 0);
            end
            8'h03: begin
                exp_word = ({26'd0, i_arg[5:0]} * 32'h01010101) ^ 32'hA5A5A5A5;
                for (int i = 0; i < 4; i++) begin
                    check_byte(exp_word[i*8 +: 8], "memory word", i);
                end
                check_byte(ACK_BYTE, "acknowledge", 0);
                if (i_mem_addr != i_arg[5:0]) begin
                    $display("[ERROR] %0t: o_mem_addr is %h, expected %h",
                             $time, i_mem_addr, i_arg[5:0]);
                    errors++;
                end
            end
            8'h04, 8'h05: begin
                check_byte(ACK_BYTE, "acknowledge", 0);
                if (i_step_enable != (i_kind == 8'h05)) begin
                    $display("[ERROR] %0t: o_step_enable is %b after mode command %h",
                             $time, i_step_enable, i_cmd);
                    errors++;
                end
            end
            8'h06: begin
                check_quiet(high_cycles);
                if (high_cycles != 1 || i_step_enable) begin
                    $display("[ERROR] %0t: step gave %0d high cycles, expected 1",
                             $time, high_cycles);
                    errors++;
                end
            end
            8'h00: check_quiet(high_cycles);
            default: begin
                $display("tests file has an unknown result kind %h", i_kind);
                errors++;
            end
        endcase
        test_num++;
        if (errors == 0) begin
            o_passed++;
            $display("test %0d: command %h argument %h ok", test_num, i_cmd, i_arg);
        end else begin
            o_failed++;
            $display("test %0d: command %h argument %h FAILED with %0d errors",
                     test_num, i_cmd, i_arg, errors);
        end
    endtask

    initial begin
        o_idle   = 1'b1;
        o_passed = 0;
        o_failed = 0;
        test_num = 0;
        errors   = 0;
        forever begin
            @(negedge i_clk);
            if (i_start) begin
                o_idle = 1'b0;
                run_test();
                o_idle = 1'b1;
            end
        end
    end

endmodule

// ==== verification/debug_unit_tb.sv ====
`timescale 1ns/10ps

module debug_unit_tb import debug_pkg::*; ();

    localparam int CLKS_PER_TICK = 2;
    localparam int BIT_CLKS      = OVERSAMPLE * CLKS_PER_TICK;
    localparam int MAX_TESTS     = 64;
    localparam int TEST_TIMEOUT  = 100000;  // Well above a register dump of about 42k clocks

    logic      clk;
    logic      i_reset;
    logic      uart_rx;
    regfile_t  registers;
    if_id_t    if_id;
    word_t     mem_data;
    logic      uart_tx;
    mem_addr_t mem_addr;
    logic      step_enable;

    logic      chk_start;
    byte_t     chk_cmd;
    byte_t     chk_arg;
    byte_t     chk_kind;
    logic      chk_idle;
    int        chk_passed;
    int        chk_failed;

    byte_t     tests [0:3*MAX_TESTS-1];  // Command, argument, result kind

    always #2 clk = ~clk;

    // Combinational data memory
    assign mem_data = ({26'd0, mem_addr} * 32'h01010101) ^ 32'hA5A5A5A5;

    debug_unit #(.CLKS_PER_TICK(CLKS_PER_TICK), .NUM_REQ(4)) dut (
        .i_clk(clk), .i_reset(i_reset), .i_uart_rx(uart_rx),
        .i_registers(registers), .i_if_id(if_id), .i_mem_data(mem_data),
        .o_uart_tx(uart_tx), .o_mem_addr(mem_addr), .o_step_enable(step_enable)
    );

    debug_unit_checker #(.BIT_CLKS(BIT_CLKS)) u_checker (
        .i_clk(clk), .i_tx(uart_tx), .i_step_enable(step_enable), .i_mem_addr(mem_addr),
        .i_registers(registers), .i_if_id(if_id),
        .i_start(chk_start), .i_cmd(chk_cmd), .i_arg(chk_arg), .i_kind(chk_kind),
        .o_idle(chk_idle), .o_passed(chk_passed), .o_failed(chk_failed)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 8N1 frame sent LSB first
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    task automatic wait_checker_idle(input int n);
        int t;
        t = 0;
        while (!chk_idle && t < TEST_TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (!chk_idle) begin
            $display("timeout: checker did not finish test %0d", n);
            $display("test failed");
            $finish;
        end
    endtask

    initial begin
        int         n;
        regfile_t   regs_init;
        logic [31:0] seed;
        clk       = 1'b0;
        i_reset   = 1'b1;
        uart_rx   = 1'b1;
        registers = '0;
        if_id     = '0;
        chk_start = 1'b0;
        chk_cmd   = '0;
        chk_arg   = '0;
        chk_kind  = '0;
        seed      = 32'h979726a1;
        regs_init = '0;
        for (int k = 0; k < 3 * MAX_TESTS; k++) begin
            tests[k] = 8'hFF;  // Unused entries end the list
        end
        $readmemh("verification/debug_tests.txt", tests);

        repeat (16) @(posedge clk);
        i_reset <= 1'b0;

        @(posedge clk);
        for (int r = 0; r < NUM_REGISTERS; r++) begin
            seed = lcg_next(seed);
            regs_init[r*32 +: 32] = seed;
        end
        seed = lcg_next(seed);
        registers <= regs_init;
        if_id     <= seed;
        repeat (4) @(posedge clk);

        n = 0;
        while (n < MAX_TESTS && tests[3*n+2] != 8'hFF) begin
            @(posedge clk);
            chk_cmd   <= tests[3*n];
            chk_arg   <= tests[3*n+1];
            chk_kind  <= tests[3*n+2];
            chk_start <= 1'b1;
            @(posedge clk);
            chk_start <= 1'b0;
            send_byte(tests[3*n]);
            if (tests[3*n+2] == 8'h03) begin
                send_byte(tests[3*n+1]);  // Address byte
            end
            wait_checker_idle(n);
            repeat (50) @(posedge clk);
            n++;
        end

        $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 n, chk_passed, chk_failed, dut.u_arbiter.u_assertions.failures);
        if (chk_failed == 0 && n > 0 && dut.u_arbiter.u_assertions.failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verification/debug_tests.txt ====
// command argument kind (00 none, 01 regs, 02 IF/ID, 03 memory, 04 step mode,
// 05 continuous mode, 06 single step pulse)
01 00 01
02 00 02
0B 05 03
0B 2A 03
0B FF 03
09 00 04
0A 00 06
0A 00 06
02 00 02
08 00 05
0A 00 00
77 00 00
02 00 02
0B 3F 03
01 00 01

// ==== files.f ====
source/debug_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/command_decoder.sv
source/snapshot_sender.sv
source/tx_arbiter.sv
source/debug_unit.sv
verification/debug_unit_assertions.sv
verification/debug_unit_checker.sv
verification/debug_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = debug_unit_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
